//--- source/mips_pkg.sv
// shared widths, opcodes, ALU codes and state types for the MIPS system, referenced by scoped name
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  pc_sel_t;
  typedef logic [1:0]  axil_resp_t;

  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDI  = 6'h08;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  localparam funct_t FN_JR      = 6'h08;
  localparam funct_t FN_SYSCALL = 6'h0c;
  localparam funct_t FN_ADD     = 6'h20;
  localparam funct_t FN_SUB     = 6'h22;
  localparam funct_t FN_AND     = 6'h24;
  localparam funct_t FN_OR      = 6'h25;
  localparam funct_t FN_SLT     = 6'h2a;

  // classic MIPS ALU control encodings
  localparam alu_op_t ALU_AND = 4'd0;
  localparam alu_op_t ALU_OR  = 4'd1;
  localparam alu_op_t ALU_ADD = 4'd2;
  localparam alu_op_t ALU_SUB = 4'd6;
  localparam alu_op_t ALU_SLT = 4'd7;

  localparam pc_sel_t PC_SEQ    = 2'd0; // pc + 4
  localparam pc_sel_t PC_BRANCH = 2'd1;
  localparam pc_sel_t PC_JUMP   = 2'd2;
  localparam pc_sel_t PC_REG    = 2'd3; // jr

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    CORE_STOPPED,
    CORE_RUNNING,
    CORE_HALTED
  } core_state_t;

  typedef enum logic {
    BUS_IDLE,
    BUS_RESP
  } bus_state_t;

endpackage

//--- source/mem_bus_if.sv
// word access bus from the AXI loader into one memory, host drives and memory answers
`timescale 1ns/1ps

interface mem_bus_if;

  mips_pkg::word_t addr;  // word index, not byte address
  mips_pkg::word_t wdata;
  mips_pkg::word_t rdata;
  logic            we;

  modport host (
    output addr, wdata, we,
    input  rdata
  );

  modport mem (
    input  addr, wdata, we,
    output rdata
  );

endinterface

//--- source/alu.sv
// word ALU for the core: add, sub, and, or and signed set-less-than, plus a zero flag
`timescale 1ns/1ps

module alu (
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  mips_pkg::alu_op_t op,
  output mips_pkg::word_t   result,
  output logic              zero
);

  always_comb begin
    case (op)
      mips_pkg::ALU_ADD: result = a + b; // wraps mod 2^32
      mips_pkg::ALU_SUB: result = a - b;
      mips_pkg::ALU_AND: result = a & b;
      mips_pkg::ALU_OR:  result = a | b;
      mips_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      default:           result = '0;
    endcase
  end

  assign zero = result == '0; // used by beq/bne

endmodule

//--- source/reg_file.sv
// 32 x 32 register file, two combinational read ports and one write port, r0 reads zero
`timescale 1ns/1ps

module reg_file (
  input  logic                clock,
  input  logic                rst,
  input  mips_pkg::reg_addr_t raddr_a,
  input  mips_pkg::reg_addr_t raddr_b,
  input  mips_pkg::reg_addr_t waddr,
  input  mips_pkg::word_t     wdata,
  input  logic                we,
  output mips_pkg::word_t     rdata_a,
  output mips_pkg::word_t     rdata_b
);

  mips_pkg::word_t regs [32];

  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin // r0 stays zero
      regs[waddr] <= wdata;
    end
  end

endmodule

//--- source/instr_decode.sv
// instruction field split and control decode for the single-cycle core, purely combinational
`timescale 1ns/1ps

module instr_decode (
  input  mips_pkg::word_t     instr,
  output mips_pkg::reg_addr_t rs,
  output mips_pkg::reg_addr_t rt,
  output mips_pkg::reg_addr_t rd,
  output mips_pkg::word_t     imm,
  output logic [25:0]         jump_target,
  output mips_pkg::alu_op_t   alu_op,
  output logic                alu_src_imm,
  output logic                reg_write,
  output logic                mem_write,
  output logic                mem_to_reg,
  output logic                link,
  output logic                halt,
  output logic                branch_eq,
  output logic                branch_ne,
  output mips_pkg::pc_sel_t   pc_sel_jump
);

  mips_pkg::opcode_t opcode;
  mips_pkg::funct_t  funct;

  assign opcode      = instr[31:26];
  assign funct       = instr[5:0];
  assign rs          = instr[25:21];
  assign rt          = instr[20:16];
  assign rd          = instr[15:11];
  assign imm         = {{16{instr[15]}}, instr[15:0]};
  assign jump_target = instr[25:0];

  always_comb begin
    // unknown opcodes fall through as no-ops
    alu_op      = mips_pkg::ALU_ADD;
    alu_src_imm = 1'b0;
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    mem_to_reg  = 1'b0;
    link        = 1'b0;
    halt        = 1'b0;
    branch_eq   = 1'b0;
    branch_ne   = 1'b0;
    pc_sel_jump = mips_pkg::PC_SEQ;
    case (opcode)
      mips_pkg::OP_RTYPE: begin
        reg_write = 1'b1;
        case (funct)
          mips_pkg::FN_ADD: alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:  alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
          mips_pkg::FN_JR: begin
            reg_write   = 1'b0;
            pc_sel_jump = mips_pkg::PC_REG;
          end
          mips_pkg::FN_SYSCALL: begin
            reg_write = 1'b0;
            halt      = 1'b1;
          end
          default: reg_write = 1'b0;
        endcase
      end
      mips_pkg::OP_ADDI: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      mips_pkg::OP_LW: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        mem_to_reg  = 1'b1;
      end
      mips_pkg::OP_SW: begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      mips_pkg::OP_BEQ: begin
        alu_op    = mips_pkg::ALU_SUB; // compare by subtract
        branch_eq = 1'b1;
      end
      mips_pkg::OP_BNE: begin
        alu_op    = mips_pkg::ALU_SUB;
        branch_ne = 1'b1;
      end
      mips_pkg::OP_J: pc_sel_jump = mips_pkg::PC_JUMP;
      mips_pkg::OP_JAL: begin
        pc_sel_jump = mips_pkg::PC_JUMP;
        reg_write   = 1'b1;
        link        = 1'b1; // r31 gets pc + 4
      end
      default: ;
    endcase
  end

endmodule

//--- source/cpu_core.sv
// single-cycle MIPS core: PC, run/halt control, datapath muxes and next-PC selection
`timescale 1ns/1ps

module cpu_core (
  input  logic            clock,
  input  logic            rst,
  input  logic            run,
  output logic            halted,
  output mips_pkg::word_t fetch_addr,
  input  mips_pkg::word_t fetch_instr,
  output mips_pkg::word_t dmem_addr,
  output mips_pkg::word_t dmem_wdata,
  output logic            dmem_we,
  input  mips_pkg::word_t dmem_rdata
);

  mips_pkg::core_state_t state;
  mips_pkg::word_t       pc, pc_plus4, next_pc;
  mips_pkg::word_t       branch_target, jump_addr;
  mips_pkg::reg_addr_t   rs, rt, rd, wr_reg;
  mips_pkg::word_t       imm, rs_data, rt_data, alu_b, alu_result, wb_data;
  logic [25:0]           jump_target;
  mips_pkg::alu_op_t     alu_op;
  mips_pkg::pc_sel_t     pc_sel_jump, pc_sel;
  logic alu_src_imm, reg_write, mem_write, mem_to_reg, link, halt;
  logic branch_eq, branch_ne, zero, active;

  instr_decode u_instr_decode (
    .instr(fetch_instr), .rs(rs), .rt(rt), .rd(rd), .imm(imm),
    .jump_target(jump_target), .alu_op(alu_op), .alu_src_imm(alu_src_imm),
    .reg_write(reg_write), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
    .link(link), .halt(halt), .branch_eq(branch_eq), .branch_ne(branch_ne),
    .pc_sel_jump(pc_sel_jump)
  );

  reg_file u_reg_file (
    .clock(clock), .rst(rst), .raddr_a(rs), .raddr_b(rt), .waddr(wr_reg),
    .wdata(wb_data), .we(reg_write && active), .rdata_a(rs_data), .rdata_b(rt_data)
  );

  alu u_alu (.a(rs_data), .b(alu_b), .op(alu_op), .result(alu_result), .zero(zero));

  // writes only land while running with run still set
  assign active = (state == mips_pkg::CORE_RUNNING) && run;
  assign halted = state == mips_pkg::CORE_HALTED;

  assign alu_b   = alu_src_imm ? imm : rt_data;
  assign wr_reg  = link ? 5'd31 : (alu_src_imm ? rt : rd);
  assign wb_data = link ? pc_plus4 : (mem_to_reg ? dmem_rdata : alu_result);

  assign fetch_addr = pc;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rt_data;
  assign dmem_we    = mem_write && active;

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm[29:0], 2'b00};
  assign jump_addr     = {pc_plus4[31:28], jump_target, 2'b00};

  always_comb begin
    pc_sel = pc_sel_jump;
    if ((branch_eq && zero) || (branch_ne && !zero)) pc_sel = mips_pkg::PC_BRANCH;
    case (pc_sel)
      mips_pkg::PC_BRANCH: next_pc = branch_target;
      mips_pkg::PC_JUMP:   next_pc = jump_addr;
      mips_pkg::PC_REG:    next_pc = rs_data;
      default:             next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= mips_pkg::CORE_STOPPED;
      pc    <= '0;
    end else if (!run) begin
      state <= mips_pkg::CORE_STOPPED; // clearing run also clears halted
      pc    <= '0;
    end else if (state == mips_pkg::CORE_STOPPED) begin
      state <= mips_pkg::CORE_RUNNING;
    end else if (state == mips_pkg::CORE_RUNNING) begin
      if (halt) state <= mips_pkg::CORE_HALTED; // pc freezes on syscall
      else      pc    <= next_pc;
    end
  end

endmodule

//--- source/instr_mem.sv
// instruction RAM, loaded and read back by the host, fetched combinationally by the core
`timescale 1ns/1ps

module instr_mem #(
  parameter int IMEM_WORDS = 256
) (
  input  logic            clock,
  mem_bus_if.mem          host,
  input  mips_pkg::word_t fetch_addr,
  output mips_pkg::word_t fetch_instr
);

  localparam int AW = $clog2(IMEM_WORDS);

  mips_pkg::word_t mem [IMEM_WORDS];

  // upper address bits are dropped, so accesses wrap
  assign host.rdata  = mem[host.addr[AW-1:0]];
  assign fetch_instr = mem[fetch_addr[AW+1:2]]; // byte PC to word index

  always_ff @(posedge clock) begin
    if (host.we) mem[host.addr[AW-1:0]] <= host.wdata;
  end

endmodule

//--- source/data_mem.sv
// data RAM shared by host and core, the core owns the write port while run is set
`timescale 1ns/1ps

module data_mem #(
  parameter int DMEM_WORDS = 256
) (
  input  logic            clock,
  mem_bus_if.mem          host,
  input  logic            run,
  input  mips_pkg::word_t cpu_addr,
  input  mips_pkg::word_t cpu_wdata,
  input  logic            cpu_we,
  output mips_pkg::word_t cpu_rdata
);

  localparam int AW = $clog2(DMEM_WORDS);

  mips_pkg::word_t mem [DMEM_WORDS];
  logic [AW-1:0]   cpu_idx, wr_idx;
  mips_pkg::word_t wr_data;
  logic            wr_en;

  assign cpu_idx = cpu_addr[AW+1:2]; // byte address to word index

  assign host.rdata = mem[host.addr[AW-1:0]];
  assign cpu_rdata  = mem[cpu_idx];

  // single write port
  assign wr_en   = run ? cpu_we : host.we;
  assign wr_idx  = run ? cpu_idx : host.addr[AW-1:0];
  assign wr_data = run ? cpu_wdata : host.wdata;

  always_ff @(posedge clock) begin
    if (wr_en) mem[wr_idx] <= wr_data;
  end

endmodule

//--- source/axil_loader.sv
// AXI4-Lite slave giving a host access to both memories and the run/halted control register
`timescale 1ns/1ps

module axil_loader (
  input  logic                   clock,
  input  logic                   rst,
  input  mips_pkg::word_t        awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  mips_pkg::word_t        wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output mips_pkg::axil_resp_t   bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  mips_pkg::word_t        araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output mips_pkg::word_t        rdata,
  output mips_pkg::axil_resp_t   rresp,
  output logic                   rvalid,
  input  logic                   rready,
  mem_bus_if.host                imem,
  mem_bus_if.host                dmem,
  output logic                   run,
  input  logic                   halted
);

  mips_pkg::bus_state_t wr_state;
  mips_pkg::bus_state_t rd_state;
  logic            wr_go, rd_go;
  logic            aw_imem, aw_dmem, aw_ctrl, wr_err;
  logic            ar_imem, ar_dmem, ar_ctrl, rd_err;
  logic            full_strobe;
  mips_pkg::word_t rd_value;

  // region decode, low two address bits ignored
  assign aw_imem = awaddr[31:12] == 20'h00000;
  assign aw_dmem = awaddr[31:12] == 20'h00001;
  assign aw_ctrl = awaddr[31:2] == 30'h00000800;
  assign ar_imem = araddr[31:12] == 20'h00000;
  assign ar_dmem = araddr[31:12] == 20'h00001;
  assign ar_ctrl = araddr[31:2] == 30'h00000800;

  // memories are locked while the core runs
  assign wr_err = ((aw_imem || aw_dmem) && run) || !(aw_imem || aw_dmem || aw_ctrl);
  assign rd_err = ((ar_imem || ar_dmem) && run) || !(ar_imem || ar_dmem || ar_ctrl);

  assign full_strobe = wstrb == 4'hf;

  assign wr_go   = (wr_state == mips_pkg::BUS_IDLE) && awvalid && wvalid;
  assign awready = wr_go;
  assign wready  = wr_go;
  assign bvalid  = wr_state == mips_pkg::BUS_RESP;

  // a write owns the memory address this cycle, so the read waits one cycle
  assign arready = (rd_state == mips_pkg::BUS_IDLE) && !wr_go;
  assign rd_go   = arready && arvalid;
  assign rvalid  = rd_state == mips_pkg::BUS_RESP;

  assign imem.addr  = wr_go ? {22'b0, awaddr[11:2]} : {22'b0, araddr[11:2]};
  assign imem.wdata = wdata;
  assign imem.we    = wr_go && aw_imem && !run && full_strobe;
  assign dmem.addr  = wr_go ? {22'b0, awaddr[11:2]} : {22'b0, araddr[11:2]};
  assign dmem.wdata = wdata;
  assign dmem.we    = wr_go && aw_dmem && !run && full_strobe;

  always_comb begin
    if (rd_err)       rd_value = '0;
    else if (ar_imem) rd_value = imem.rdata;
    else if (ar_dmem) rd_value = dmem.rdata;
    else              rd_value = {30'b0, halted, run};
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      wr_state <= mips_pkg::BUS_IDLE;
      run      <= 1'b0;
    end else begin
      case (wr_state)
        mips_pkg::BUS_IDLE: if (wr_go) wr_state <= mips_pkg::BUS_RESP;
        default:            if (bready) wr_state <= mips_pkg::BUS_IDLE;
      endcase
      if (wr_go && aw_ctrl && full_strobe) run <= wdata[0];
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      rd_state <= mips_pkg::BUS_IDLE;
    end else begin
      case (rd_state)
        mips_pkg::BUS_IDLE: if (rd_go) rd_state <= mips_pkg::BUS_RESP;
        default:            if (rready) rd_state <= mips_pkg::BUS_IDLE;
      endcase
    end
  end

  // response payload, held until the handshake completes
  always_ff @(posedge clock) begin
    if (wr_go) bresp <= wr_err ? mips_pkg::RESP_SLVERR : mips_pkg::RESP_OKAY;
    if (rd_go) begin
      rdata <= rd_value;
      rresp <= rd_err ? mips_pkg::RESP_SLVERR : mips_pkg::RESP_OKAY;
    end
  end

endmodule

//--- source/mips_system.sv
// top level of the MIPS subsystem: AXI4-Lite loader, single-cycle core and both memories
`timescale 1ns/1ps

module mips_system #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic                 clock,
  input  logic                 rst,
  input  mips_pkg::word_t      awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  mips_pkg::word_t      wdata,
  input  logic [3:0]           wstrb,
  input  logic                 wvalid,
  output logic                 wready,
  output mips_pkg::axil_resp_t bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  mips_pkg::word_t      araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output mips_pkg::word_t      rdata,
  output mips_pkg::axil_resp_t rresp,
  output logic                 rvalid,
  input  logic                 rready,
  output logic                 halted
);

  mips_pkg::word_t fetch_addr, fetch_instr;
  mips_pkg::word_t dmem_addr, dmem_wdata, dmem_rdata;
  logic            dmem_we;
  logic            run;

  mem_bus_if imem_bus ();
  mem_bus_if dmem_bus ();

  axil_loader u_axil_loader (
    .clock(clock), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .imem(imem_bus), .dmem(dmem_bus), .run(run), .halted(halted)
  );

  cpu_core u_cpu_core (
    .clock(clock), .rst(rst), .run(run), .halted(halted),
    .fetch_addr(fetch_addr), .fetch_instr(fetch_instr),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata)
  );

  instr_mem #(.IMEM_WORDS(IMEM_WORDS)) u_instr_mem (
    .clock(clock), .host(imem_bus), .fetch_addr(fetch_addr), .fetch_instr(fetch_instr)
  );

  data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_data_mem (
    .clock(clock), .host(dmem_bus), .run(run),
    .cpu_addr(dmem_addr), .cpu_wdata(dmem_wdata), .cpu_we(dmem_we), .cpu_rdata(dmem_rdata)
  );

endmodule

//--- bench/tb_mips_system.sv
// directed testbench for mips_system that loads programs over AXI4-Lite, runs the core and checks memory
`timescale 1ns/1ps

module tb_mips_system;

  // ~150 bus transfers of up to ~15 cycles each plus short programs and a wide margin
  localparam int CYCLE_LIMIT = 20000;
  localparam mips_pkg::word_t CTRL_ADDR = 32'h0000_2000;
  localparam mips_pkg::word_t DMEM_BASE = 32'h0000_1000;
  localparam mips_pkg::word_t NO_MAP    = 32'h0000_3000;

  logic                 clock, rst;
  mips_pkg::word_t      awaddr, wdata, araddr, rdata;
  logic                 awvalid, awready, wvalid, wready, bvalid, bready;
  logic                 arvalid, arready, rvalid, rready, halted;
  logic [3:0]           wstrb;
  mips_pkg::axil_resp_t bresp, rresp;

  int              errors, checks, tests, test_err_start, cycle_count;
  mips_pkg::word_t prog [$];

  mips_system u_mips_system (
    .clock(clock), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .halted(halted)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input mips_pkg::word_t got,
                            input mips_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input mips_pkg::axil_resp_t got,
                            input mips_pkg::axil_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // instruction encoders in the MIPS field layout
  function automatic mips_pkg::word_t r_type(input int rs, input int rt, input int rd,
                                             input mips_pkg::funct_t fn);
    return {mips_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic mips_pkg::word_t i_type(input mips_pkg::opcode_t op, input int rs,
                                             input int rt, input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic mips_pkg::word_t j_type(input mips_pkg::opcode_t op, input int addr);
    return {op, addr[27:2]}; // byte address to target field
  endfunction

  task automatic axi_write(input mips_pkg::word_t addr, input mips_pkg::word_t data,
                           input int stall, output mips_pkg::axil_resp_t resp);
    @(posedge clock);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    @(negedge clock);
    while (!(awready && wready)) @(negedge clock);
    @(posedge clock); // accepted on this edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clock);
    while (!bvalid) @(negedge clock);
    resp = bresp;
    repeat (stall) begin
      @(negedge clock);
      check_bit("bvalid", bvalid, 1'b1);
      check_resp("bresp", bresp, resp);
    end
    @(posedge clock);
    bready <= 1'b1;
    @(posedge clock);
    bready <= 1'b0;
    @(negedge clock);
    check_bit("bvalid", bvalid, 1'b0);
  endtask

  task automatic axi_read(input mips_pkg::word_t addr, input int stall,
                          output mips_pkg::word_t data, output mips_pkg::axil_resp_t resp);
    @(posedge clock);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clock);
    while (!arready) @(negedge clock);
    @(posedge clock);
    arvalid <= 1'b0;
    @(negedge clock);
    while (!rvalid) @(negedge clock);
    data = rdata;
    resp = rresp;
    repeat (stall) begin // held until rready
      @(negedge clock);
      check_bit("rvalid", rvalid, 1'b1);
      check_word("rdata", rdata, data);
      check_resp("rresp", rresp, resp);
    end
    @(posedge clock);
    rready <= 1'b1;
    @(posedge clock);
    rready <= 1'b0;
    @(negedge clock);
    check_bit("rvalid", rvalid, 1'b0);
  endtask

  task automatic write_and_check(input mips_pkg::word_t addr, input mips_pkg::word_t data,
                                 input mips_pkg::axil_resp_t exp_resp);
    mips_pkg::axil_resp_t resp;
    axi_write(addr, data, 0, resp);
    check_resp("bresp", resp, exp_resp);
  endtask

  task automatic read_and_check(input mips_pkg::word_t addr, input mips_pkg::word_t exp,
                                input mips_pkg::axil_resp_t exp_resp);
    mips_pkg::word_t      data;
    mips_pkg::axil_resp_t resp;
    axi_read(addr, 0, data, resp);
    check_resp("rresp", resp, exp_resp);
    check_word("rdata", data, exp);
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) write_and_check(4 * i, prog[i], mips_pkg::RESP_OKAY);
  endtask

  task automatic run_to_halt();
    write_and_check(CTRL_ADDR, 32'd1, mips_pkg::RESP_OKAY);
    @(negedge clock);
    while (!halted) @(negedge clock);
    read_and_check(CTRL_ADDR, 32'd3, mips_pkg::RESP_OKAY); // run and halted
    write_and_check(CTRL_ADDR, 32'd0, mips_pkg::RESP_OKAY);
    @(negedge clock);
    check_bit("halted", halted, 1'b0);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err_start) $display("%s: passed", name);
    else $display("%s: %0d errors", name, errors - test_err_start);
    test_err_start = errors;
  endtask

  task automatic test_reset();
    @(negedge clock);
    check_bit("halted", halted, 1'b0);
    check_bit("bvalid", bvalid, 1'b0);
    check_bit("rvalid", rvalid, 1'b0);
    check_bit("awready", awready, 1'b0);
    check_bit("wready", wready, 1'b0);
    check_bit("arready", arready, 1'b1);
    read_and_check(CTRL_ADDR, 32'd0, mips_pkg::RESP_OKAY);
    end_test("reset state");
  endtask

  task automatic test_host_access();
    mips_pkg::word_t addr, data;
    for (int i = 0; i < 8; i++) begin
      addr = (i[0] ? DMEM_BASE : 32'd0) + 4 * ($urandom % 256);
      data = $urandom;
      write_and_check(addr, data, mips_pkg::RESP_OKAY);
      read_and_check(addr, data, mips_pkg::RESP_OKAY);
    end
    write_and_check(NO_MAP, 32'h1234_5678, mips_pkg::RESP_SLVERR);
    read_and_check(NO_MAP, 32'd0, mips_pkg::RESP_SLVERR);
    end_test("host memory access");
  endtask

  task automatic test_arith();
    mips_pkg::word_t a, b, rnd;
    mips_pkg::word_t exp_vals [6];
    rnd = $urandom;
    a = {{16{rnd[15]}}, rnd[15:0]}; // addi sign extends
    b = {{16{rnd[31]}}, rnd[31:16]};
    exp_vals[0] = a + b;
    exp_vals[1] = a - b;
    exp_vals[2] = a & b;
    exp_vals[3] = a | b;
    exp_vals[4] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    exp_vals[5] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    prog.delete();
    prog.push_back(i_type(mips_pkg::OP_ADDI, 0, 1, a[15:0]));
    prog.push_back(i_type(mips_pkg::OP_ADDI, 0, 2, b[15:0]));
    prog.push_back(r_type(1, 2, 3, mips_pkg::FN_ADD));
    prog.push_back(r_type(1, 2, 4, mips_pkg::FN_SUB));
    prog.push_back(r_type(1, 2, 5, mips_pkg::FN_AND));
    prog.push_back(r_type(1, 2, 6, mips_pkg::FN_OR));
    prog.push_back(r_type(1, 2, 7, mips_pkg::FN_SLT));
    prog.push_back(r_type(2, 1, 8, mips_pkg::FN_SLT));
    for (int k = 0; k < 6; k++) prog.push_back(i_type(mips_pkg::OP_SW, 0, 3 + k, 16'(4 * k)));
    prog.push_back(r_type(0, 0, 0, mips_pkg::FN_SYSCALL));
    load_program();
    run_to_halt();
    for (int k = 0; k < 6; k++) begin
      read_and_check(DMEM_BASE + 4 * k, exp_vals[k], mips_pkg::RESP_OKAY);
    end
    end_test("arithmetic program");
  endtask

  task automatic test_control_flow();
    int n;
    n = 3 + $urandom % 8;
    prog.delete();
    prog.push_back(i_type(mips_pkg::OP_ADDI, 0, 1, 16'(n)));    // r1 counts down
    prog.push_back(i_type(mips_pkg::OP_ADDI, 0, 3, 16'd0));
    prog.push_back(i_type(mips_pkg::OP_ADDI, 0, 2, 16'd0));
    prog.push_back(r_type(2, 1, 2, mips_pkg::FN_ADD));          // loop at 12
    prog.push_back(i_type(mips_pkg::OP_ADDI, 3, 3, 16'd1));
    prog.push_back(i_type(mips_pkg::OP_ADDI, 1, 1, 16'hffff));
    prog.push_back(i_type(mips_pkg::OP_BNE, 1, 0, 16'hfffc));
    prog.push_back(i_type(mips_pkg::OP_SW, 0, 2, 16'd32));
    prog.push_back(i_type(mips_pkg::OP_SW, 0, 3, 16'd36));
    prog.push_back(j_type(mips_pkg::OP_JAL, 68));               // at 36
    prog.push_back(i_type(mips_pkg::OP_SW, 0, 31, 16'd40));
    prog.push_back(i_type(mips_pkg::OP_SW, 0, 6, 16'd44));
    prog.push_back(i_type(mips_pkg::OP_LW, 0, 5, 16'd32));
    prog.push_back(i_type(mips_pkg::OP_BEQ, 5, 2, 16'd1));      // skips the next one
    prog.push_back(i_type(mips_pkg::OP_ADDI, 0, 9, 16'd1));
    prog.push_back(i_type(mips_pkg::OP_SW, 0, 9, 16'd48));
    prog.push_back(r_type(0, 0, 0, mips_pkg::FN_SYSCALL));
    prog.push_back(i_type(mips_pkg::OP_ADDI, 0, 6, 16'h0123));  // routine at 68
    prog.push_back(r_type(31, 0, 0, mips_pkg::FN_JR));
    load_program();
    run_to_halt();
    read_and_check(DMEM_BASE + 32, n * (n + 1) / 2, mips_pkg::RESP_OKAY);
    read_and_check(DMEM_BASE + 36, n, mips_pkg::RESP_OKAY);
    read_and_check(DMEM_BASE + 40, 36 + 4, mips_pkg::RESP_OKAY); // jal address + 4
    read_and_check(DMEM_BASE + 44, 32'h0000_0123, mips_pkg::RESP_OKAY);
    read_and_check(DMEM_BASE + 48, 32'd0, mips_pkg::RESP_OKAY);
    end_test("control flow program");
  endtask

  task automatic test_locked_memory();
    mips_pkg::word_t pattern;
    pattern = $urandom;
    write_and_check(DMEM_BASE + 32'h50, pattern, mips_pkg::RESP_OKAY);
    prog.delete();
    prog.push_back(j_type(mips_pkg::OP_J, 0)); // spins forever
    load_program();
    write_and_check(CTRL_ADDR, 32'd1, mips_pkg::RESP_OKAY);
    read_and_check(CTRL_ADDR, 32'd1, mips_pkg::RESP_OKAY);
    write_and_check(DMEM_BASE + 32'h50, ~pattern, mips_pkg::RESP_SLVERR);
    read_and_check(DMEM_BASE + 32'h50, 32'd0, mips_pkg::RESP_SLVERR);
    write_and_check(32'd0, 32'd0, mips_pkg::RESP_SLVERR);
    read_and_check(32'd0, 32'd0, mips_pkg::RESP_SLVERR);
    write_and_check(CTRL_ADDR, 32'd0, mips_pkg::RESP_OKAY);
    read_and_check(DMEM_BASE + 32'h50, pattern, mips_pkg::RESP_OKAY);
    read_and_check(32'd0, prog[0], mips_pkg::RESP_OKAY);
    end_test("memory locked while running");
  endtask

  task automatic test_back_pressure();
    mips_pkg::word_t      addr, data, got;
    mips_pkg::axil_resp_t resp;
    for (int i = 0; i < 4; i++) begin
      addr = DMEM_BASE + 4 * ($urandom % 256);
      data = $urandom;
      axi_write(addr, data, 1 + $urandom % 8, resp);
      check_resp("bresp", resp, mips_pkg::RESP_OKAY);
      axi_read(addr, 1 + $urandom % 8, got, resp);
      check_resp("rresp", resp, mips_pkg::RESP_OKAY);
      check_word("rdata", got, data);
    end
    axi_write(NO_MAP, 32'hffff_ffff, 1 + $urandom % 8, resp);
    check_resp("bresp", resp, mips_pkg::RESP_SLVERR);
    axi_read(NO_MAP, 1 + $urandom % 8, got, resp);
    check_resp("rresp", resp, mips_pkg::RESP_SLVERR);
    end_test("response back-pressure");
  endtask

  initial begin
    void'($urandom(32'hb570));
    clock   = 1'b0;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'h0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (16) @(posedge clock);
    rst <= 1'b0;
    test_reset();
    test_host_access();
    test_arith();
    test_control_flow();
    test_locked_memory();
    test_back_pressure();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- mips_system.f
source/mips_pkg.sv
source/mem_bus_if.sv
source/alu.sv
source/reg_file.sv
source/instr_decode.sv
source/cpu_core.sv
source/instr_mem.sv
source/data_mem.sv
source/axil_loader.sv
source/mips_system.sv
bench/tb_mips_system.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mips_system.f --top-module tb_mips_system -o tb_sim \
  > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log

grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL: no result"; exit 1; }
